// File: backend_cfg_pkg.sv
// fixed back end sizes; ROB_DEPTH must equal 2**ROB_IDX_LEN and REG_N must equal 2**REG_IDX_LEN
`default_nettype none

package backend_cfg_pkg;

    // datapath and instruction word widths
    localparam int XLEN        = 32;
    localparam int ILEN        = 32;

    // architectural integer registers, x0 included
    localparam int REG_N       = 32;
    localparam int REG_IDX_LEN = 5;

    // reorder buffer, pointers wrap naturally
    localparam int ROB_DEPTH   = 8;
    localparam int ROB_IDX_LEN = 3;

    // identical execution slots behind the issue stage
    localparam int EU_N        = 4;

endpackage

`default_nettype wire

// File: backend_types_pkg.sv
// only OP and OP-IMM words are decoded; field layout follows the RV32 base formats
`default_nettype none

package backend_types_pkg;

    import backend_cfg_pkg::*;

    // register-register layout
    typedef struct packed {
        logic [6:0]             funct7;
        logic [REG_IDX_LEN-1:0] rs2;
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    // register-immediate layout, imm12 overlays funct7 and rs2
    typedef struct packed {
        logic [11:0]            imm12;
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    // one fetched word, read in either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // ALU function codes
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;

    // source operand: value valid when rdy, else wait for tag on the bus
    typedef struct packed {
        logic                   rdy;
        logic [ROB_IDX_LEN-1:0] tag;
        logic [XLEN-1:0]        value;
    } operand_t;

    typedef struct packed {
        logic [2:0]             alu_op;
        operand_t               opa;
        operand_t               opb;
        logic [ROB_IDX_LEN-1:0] rob_idx;
    } dispatch_t;

    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] rob_idx;
        logic [XLEN-1:0]        value;
    } cdb_t;

    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [REG_IDX_LEN-1:0] rd;
    } rob_alloc_t;

    typedef struct packed {
        logic [XLEN-1:0]        pc;
        logic [REG_IDX_LEN-1:0] rd;
        logic [XLEN-1:0]        value;
    } comm_t;

endpackage

`default_nettype wire

// File: reg_state.sv
// a commit in the flush cycle still writes the register file; flush only clears busy bits
`timescale 1ns/1ps
`default_nettype none

module reg_state import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  logic [REG_IDX_LEN-1:0] rs1_idx_i,
    input  logic [REG_IDX_LEN-1:0] rs2_idx_i,
    output operand_t               rs1_o,
    output operand_t               rs2_o,
    input  logic                   rename_i,
    input  logic [REG_IDX_LEN-1:0] rename_rd_i,
    input  logic [ROB_IDX_LEN-1:0] rename_tag_i,
    input  logic                   comm_valid_i,
    input  var comm_t              comm_i,
    input  logic [ROB_IDX_LEN-1:0] comm_tag_i
);

    logic [XLEN-1:0]        regs_q [REG_N];
    logic [REG_N-1:0]       busy_q;
    logic [ROB_IDX_LEN-1:0] tag_q  [REG_N];

    // busy register hands out its producer tag, free one its value
    function automatic operand_t read_port(logic [REG_IDX_LEN-1:0] idx);
        operand_t op;
        op.rdy   = !busy_q[idx];
        op.tag   = tag_q[idx];
        // x0 reads zero whatever is stored
        op.value = (idx == '0) ? '0 : regs_q[idx];
        return op;
    endfunction

    assign rs1_o = read_port(rs1_idx_i);
    assign rs2_o = read_port(rs2_idx_i);

    // architectural write at commit, x0 never written
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < REG_N; k++) begin
                regs_q[k] <= '0;
            end
        end else if (comm_valid_i && comm_i.rd != '0) begin
            regs_q[comm_i.rd] <= comm_i.value;
        end
    end

    // register status table
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
            for (int k = 0; k < REG_N; k++) begin
                tag_q[k] <= '0;
            end
        end else if (flush_i) begin
            busy_q <= '0;
        end else begin
            // release only if no younger writer renamed it meanwhile
            if (comm_valid_i && tag_q[comm_i.rd] == comm_tag_i) begin
                busy_q[comm_i.rd] <= 1'b0;
            end
            // rename comes last so it wins on the same register
            if (rename_i) begin
                busy_q[rename_rd_i] <= 1'b1;
                tag_q[rename_rd_i]  <= rename_tag_i;
            end
        end
    end

endmodule

`default_nettype wire

// File: issue_stage.sv
// unsupported opcodes and funct3 values issue as a no-op with rd x0 and result zero
`timescale 1ns/1ps
`default_nettype none

module issue_stage import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  logic [XLEN-1:0]        fetch_pc_i,
    input  var instr_word_u        fetch_instr_i,
    input  logic                   flush_i,
    input  logic [EU_N-1:0]        slot_idle_i,
    input  logic                   rob_full_i,
    input  logic [ROB_IDX_LEN-1:0] rob_tail_i,
    output logic [REG_IDX_LEN-1:0] rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] rs2_idx_o,
    input  var operand_t           rs1_i,
    input  var operand_t           rs2_i,
    output logic [ROB_IDX_LEN-1:0] rob_rd_tag1_o,
    output logic [ROB_IDX_LEN-1:0] rob_rd_tag2_o,
    input  var operand_t           rob_rd1_i,
    input  var operand_t           rob_rd2_i,
    output logic [EU_N-1:0]        dispatch_o,
    output dispatch_t              dispatch_data_o,
    output logic                   alloc_o,
    output rob_alloc_t             alloc_data_o,
    output logic                   rename_o,
    output logic [REG_IDX_LEN-1:0] rename_rd_o
);

    logic                   is_r;
    logic                   supported;
    logic [2:0]             alu_op;
    logic [REG_IDX_LEN-1:0] rd;
    logic [XLEN-1:0]        imm;
    operand_t               opa;
    operand_t               opb_reg;
    logic [EU_N-1:0]        slot_sel;
    logic                   fire;

    assign is_r = (fetch_instr_i.r.opcode == OPC_OP);

    // decode, funct3 sits at the same place in both formats
    always_comb begin
        supported = 1'b0;
        alu_op    = ALU_ADD;
        if (is_r || fetch_instr_i.i.opcode == OPC_OP_IMM) begin
            supported = 1'b1;
            case (fetch_instr_i.r.funct3)
                // funct7 bit 5 selects sub, register format only
                3'b000:  alu_op = (is_r && fetch_instr_i.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b111:  alu_op = ALU_AND;
                3'b110:  alu_op = ALU_OR;
                3'b100:  alu_op = ALU_XOR;
                3'b010:  alu_op = ALU_SLT;
                default: supported = 1'b0;
            endcase
        end
    end

    // a no-op reads x0 twice so its sum is zero
    assign rs1_idx_o = supported ? fetch_instr_i.r.rs1 : '0;
    assign rs2_idx_o = (supported && is_r) ? fetch_instr_i.r.rs2 : '0;
    assign rd        = supported ? fetch_instr_i.r.rd : '0;

    // immediate sign is the top bit of the word
    assign imm = {{(XLEN-12){fetch_instr_i[ILEN-1]}}, fetch_instr_i.i.imm12};

    // busy operands may already sit finished in the ROB
    assign rob_rd_tag1_o = rs1_i.tag;
    assign rob_rd_tag2_o = rs2_i.tag;

    always_comb begin
        opa     = rs1_i;
        opb_reg = rs2_i;
        if (!rs1_i.rdy && rob_rd1_i.rdy) begin
            opa.rdy   = 1'b1;
            opa.value = rob_rd1_i.value;
        end
        if (!rs2_i.rdy && rob_rd2_i.rdy) begin
            opb_reg.rdy   = 1'b1;
            opb_reg.value = rob_rd2_i.value;
        end
    end

    // lowest idle slot as a one-hot mask
    assign slot_sel = slot_idle_i & (~slot_idle_i + EU_N'(1));

    assign fetch_ready_o = !rob_full_i && (|slot_idle_i) && !flush_i;
    assign fire          = fetch_valid_i && fetch_ready_o;

    assign dispatch_o              = fire ? slot_sel : '0;
    assign dispatch_data_o.alu_op  = alu_op;
    assign dispatch_data_o.opa     = opa;
    assign dispatch_data_o.opb     = (supported && !is_r) ? operand_t'{1'b1, '0, imm} : opb_reg;
    assign dispatch_data_o.rob_idx = rob_tail_i;

    // ROB entry at the tail, same tag renames rd
    assign alloc_o         = fire;
    assign alloc_data_o.pc = fetch_pc_i;
    assign alloc_data_o.rd = rd;
    assign rename_o        = fire && (rd != '0);
    assign rename_rd_o     = rd;

endmodule

`default_nettype wire

// File: exec_slot.sv
// one instruction per slot; the result is held until the bus grants it
`timescale 1ns/1ps
`default_nettype none

module exec_slot import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      flush_i,
    input  logic      dispatch_i,
    input  var dispatch_t dispatch_data_i,
    input  logic      cdb_valid_i,
    input  var cdb_t  cdb_i,
    input  logic      grant_i,
    output logic      idle_o,
    output logic      req_o,
    output cdb_t      result_o
);

    logic      busy_q;
    logic      done_q;
    dispatch_t ent_q;
    cdb_t      res_q;
    operand_t  opa_w;
    operand_t  opb_w;
    logic      go;

    // capture a broadcast for a waiting operand
    function automatic operand_t wake(operand_t op, logic vld, cdb_t bus);
        operand_t r;
        r = op;
        if (!op.rdy && vld && bus.rob_idx == op.tag) begin
            r.rdy   = 1'b1;
            r.value = bus.value;
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] alu(logic [2:0] op, logic [XLEN-1:0] a,
                                            logic [XLEN-1:0] b);
        case (op)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            default: return a + b;
        endcase
    endfunction

    // operands as seen this cycle with any bus hit
    assign opa_w = wake(ent_q.opa, cdb_valid_i, cdb_i);
    assign opb_w = wake(ent_q.opb, cdb_valid_i, cdb_i);
    assign go    = busy_q && !done_q && opa_w.rdy && opb_w.rdy;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (flush_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (dispatch_i) begin
            busy_q <= 1'b1;
            done_q <= 1'b0;
        end else if (go) begin
            done_q <= 1'b1;
        end else if (done_q && grant_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end
    end

    // entry and result payload
    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            ent_q     <= dispatch_data_i;
            // the bus is watched in the dispatch cycle too
            ent_q.opa <= wake(dispatch_data_i.opa, cdb_valid_i, cdb_i);
            ent_q.opb <= wake(dispatch_data_i.opb, cdb_valid_i, cdb_i);
        end else if (busy_q && !done_q) begin
            ent_q.opa <= opa_w;
            ent_q.opb <= opb_w;
        end
        if (go) begin
            res_q.rob_idx <= ent_q.rob_idx;
            res_q.value   <= alu(ent_q.alu_op, opa_w.value, opb_w.value);
        end
    end

    assign idle_o   = !busy_q;
    assign req_o    = done_q;
    assign result_o = res_q;

    // issue must only pick an idle slot
    ap_dispatch_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        dispatch_i |-> !busy_q);

endmodule

`default_nettype wire

// File: cdb_arbiter.sv
// fixed priority, slot 0 highest; a slot may wait forever behind lower indices
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic [EU_N-1:0] req_i,
    input  var cdb_t        result_i [EU_N],
    output logic [EU_N-1:0] grant_o,
    output logic            cdb_valid_o,
    output cdb_t            cdb_o
);

    // lowest set request bit
    assign grant_o     = req_i & (~req_i + EU_N'(1));
    assign cdb_valid_o = |req_i;

    // forward the granted slot result
    always_comb begin
        cdb_o = '0;
        for (int k = 0; k < EU_N; k++) begin
            if (grant_o[k]) begin
                cdb_o = result_i[k];
            end
        end
        // a request always wins one grant, and only a requester is granted
        assert ($onehot0(grant_o) && (grant_o & ~req_i) == '0 && (|grant_o) == cdb_valid_o)
            else $error("cdb grant is not a single requester");
    end

endmodule

`default_nettype wire

// File: rob.sv
// one allocation and one commit per cycle; a full ROB refuses allocation even while committing
`timescale 1ns/1ps
`default_nettype none

module rob import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   flush_i,
    input  logic                   alloc_i,
    input  var rob_alloc_t         alloc_data_i,
    output logic                   full_o,
    output logic [ROB_IDX_LEN-1:0] tail_o,
    input  logic [ROB_IDX_LEN-1:0] rd_tag1_i,
    input  logic [ROB_IDX_LEN-1:0] rd_tag2_i,
    output operand_t               rd1_o,
    output operand_t               rd2_o,
    input  logic                   cdb_valid_i,
    input  var cdb_t               cdb_i,
    output logic                   comm_valid_o,
    output comm_t                  comm_o,
    output logic [ROB_IDX_LEN-1:0] comm_tag_o
);

    logic [ROB_IDX_LEN-1:0] head_q;
    logic [ROB_IDX_LEN-1:0] tail_q;
    logic [ROB_IDX_LEN:0]   cnt_q;
    logic [ROB_DEPTH-1:0]   done_q;

    rob_alloc_t             info_q  [ROB_DEPTH];
    logic [XLEN-1:0]        value_q [ROB_DEPTH];

    assign full_o = (cnt_q == (ROB_IDX_LEN+1)'(ROB_DEPTH));
    assign tail_o = tail_q;

    // operand read ports, ready once the result is in
    assign rd1_o = operand_t'{done_q[rd_tag1_i], rd_tag1_i, value_q[rd_tag1_i]};
    assign rd2_o = operand_t'{done_q[rd_tag2_i], rd_tag2_i, value_q[rd_tag2_i]};

    // in-order commit of a finished head
    assign comm_valid_o = (cnt_q != '0) && done_q[head_q];
    assign comm_o.pc    = info_q[head_q].pc;
    assign comm_o.rd    = info_q[head_q].rd;
    assign comm_o.value = value_q[head_q];
    assign comm_tag_o   = head_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            done_q <= '0;
        end else if (flush_i) begin
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
            done_q <= '0;
        end else begin
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            // a broadcast tag is always in flight, never the tail
            if (cdb_valid_i) begin
                done_q[cdb_i.rob_idx] <= 1'b1;
            end
            if (comm_valid_o) begin
                head_q <= head_q + 1'b1;
            end
            cnt_q <= cnt_q + (ROB_IDX_LEN+1)'(alloc_i) - (ROB_IDX_LEN+1)'(comm_valid_o);
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            info_q[tail_q] <= alloc_data_i;
        end
        if (cdb_valid_i) begin
            value_q[cdb_i.rob_idx] <= cdb_i.value;
        end
    end

    // issue gates the fetch handshake on full
    ap_no_alloc_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        alloc_i |-> !full_o);

    // each entry gets exactly one result from the slots
    ap_single_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cdb_valid_i && !flush_i |-> !done_q[cdb_i.rob_idx]);

endmodule

`default_nettype wire

// File: back_end.sv
// integer OP and OP-IMM only; no branches, memory or exceptions, commit has no back-pressure
`timescale 1ns/1ps
`default_nettype none

module back_end import backend_cfg_pkg::*, backend_types_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            flush_i,
    input  logic            fetch_valid_i,
    output logic            fetch_ready_o,
    input  logic [XLEN-1:0] fetch_pc_i,
    input  var instr_word_u fetch_instr_i,
    output logic            comm_valid_o,
    output comm_t           comm_o
);

    // issue to register state
    logic [REG_IDX_LEN-1:0] rs1_idx;
    logic [REG_IDX_LEN-1:0] rs2_idx;
    operand_t               rs1_op;
    operand_t               rs2_op;
    logic                   rename;
    logic [REG_IDX_LEN-1:0] rename_rd;

    // issue to ROB
    logic [ROB_IDX_LEN-1:0] rob_tag1;
    logic [ROB_IDX_LEN-1:0] rob_tag2;
    operand_t               rob_op1;
    operand_t               rob_op2;
    logic                   alloc;
    rob_alloc_t             alloc_data;
    logic                   rob_full;
    logic [ROB_IDX_LEN-1:0] rob_tail;
    logic [ROB_IDX_LEN-1:0] comm_tag;

    // slots and bus
    logic [EU_N-1:0]        slot_idle;
    logic [EU_N-1:0]        dispatch;
    dispatch_t              dispatch_data;
    logic [EU_N-1:0]        slot_req;
    logic [EU_N-1:0]        slot_gnt;
    cdb_t                   slot_res [EU_N];
    logic                   cdb_valid;
    cdb_t                   cdb;

    reg_state u_reg_state (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .rs1_idx_i    (rs1_idx),
        .rs2_idx_i    (rs2_idx),
        .rs1_o        (rs1_op),
        .rs2_o        (rs2_op),
        .rename_i     (rename),
        .rename_rd_i  (rename_rd),
        // the renaming instruction takes the tail entry
        .rename_tag_i (rob_tail),
        .comm_valid_i (comm_valid_o),
        .comm_i       (comm_o),
        .comm_tag_i   (comm_tag)
    );

    issue_stage u_issue_stage (
        .fetch_valid_i   (fetch_valid_i),
        .fetch_ready_o   (fetch_ready_o),
        .fetch_pc_i      (fetch_pc_i),
        .fetch_instr_i   (fetch_instr_i),
        .flush_i         (flush_i),
        .slot_idle_i     (slot_idle),
        .rob_full_i      (rob_full),
        .rob_tail_i      (rob_tail),
        .rs1_idx_o       (rs1_idx),
        .rs2_idx_o       (rs2_idx),
        .rs1_i           (rs1_op),
        .rs2_i           (rs2_op),
        .rob_rd_tag1_o   (rob_tag1),
        .rob_rd_tag2_o   (rob_tag2),
        .rob_rd1_i       (rob_op1),
        .rob_rd2_i       (rob_op2),
        .dispatch_o      (dispatch),
        .dispatch_data_o (dispatch_data),
        .alloc_o         (alloc),
        .alloc_data_o    (alloc_data),
        .rename_o        (rename),
        .rename_rd_o     (rename_rd)
    );

    // all slots share the dispatch payload, the one-hot strobe picks one
    for (genvar g = 0; g < EU_N; g++) begin : g_slot
        exec_slot u_exec_slot (
            .clk_i           (clk_i),
            .arst_n_i        (arst_n_i),
            .flush_i         (flush_i),
            .dispatch_i      (dispatch[g]),
            .dispatch_data_i (dispatch_data),
            .cdb_valid_i     (cdb_valid),
            .cdb_i           (cdb),
            .grant_i         (slot_gnt[g]),
            .idle_o          (slot_idle[g]),
            .req_o           (slot_req[g]),
            .result_o        (slot_res[g])
        );
    end

    cdb_arbiter u_cdb_arbiter (
        .req_i       (slot_req),
        .result_i    (slot_res),
        .grant_o     (slot_gnt),
        .cdb_valid_o (cdb_valid),
        .cdb_o       (cdb)
    );

    rob u_rob (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .alloc_i      (alloc),
        .alloc_data_i (alloc_data),
        .full_o       (rob_full),
        .tail_o       (rob_tail),
        .rd_tag1_i    (rob_tag1),
        .rd_tag2_i    (rob_tag2),
        .rd1_o        (rob_op1),
        .rd2_o        (rob_op2),
        .cdb_valid_i  (cdb_valid),
        .cdb_i        (cdb),
        .comm_valid_o (comm_valid_o),
        .comm_o       (comm_o),
        .comm_tag_o   (comm_tag)
    );

endmodule

`default_nettype wire

// File: tb_ref_model.svh
// model state is architectural only; instructions still in flight live in issued_q until commit
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one accepted fetch, as seen at the handshake
typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [ILEN-1:0] word;
} issued_t;

// accepted and not yet committed, oldest first
issued_t         issued_q [$];

// committed register values
logic [XLEN-1:0] model_regs [REG_N];

function automatic void model_reset();
    for (int k = 0; k < REG_N; k++) begin
        model_regs[k] = '0;
    end
endfunction

// x0 is hardwired to zero
function automatic logic [XLEN-1:0] model_read(input logic [REG_IDX_LEN-1:0] idx);
    return (idx == '0) ? '0 : model_regs[idx];
endfunction

function automatic void model_commit(input comm_t c);
    if (c.rd != '0) begin
        model_regs[c.rd] = c.value;
    end
endfunction

// expected commit of one instruction against the committed state
function automatic comm_t ref_result(input issued_t ins);
    comm_t           res;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    opc       = ins.word[6:0];
    f3        = ins.word[14:12];
    a         = model_read(ins.word[19:15]);
    res.pc    = ins.pc;
    res.rd    = '0;
    res.value = '0;
    // register format reads rs2, immediate format sign extends bits 31:20
    if (opc == OPC_OP) begin
        b = model_read(ins.word[24:20]);
    end else begin
        b = {{(XLEN-12){ins.word[31]}}, ins.word[31:20]};
    end
    if (opc == OPC_OP || opc == OPC_OP_IMM) begin
        res.rd = ins.word[11:7];
        case (f3)
            // bit 30 is funct7 bit 5, sub only in the register format
            3'b000:  res.value = (opc == OPC_OP && ins.word[30]) ? a - b : a + b;
            3'b111:  res.value = a & b;
            3'b110:  res.value = a | b;
            3'b100:  res.value = a ^ b;
            3'b010:  res.value = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            // anything else is a no-op to x0 with zero
            default: res.rd = '0;
        endcase
    end
    return res;
endfunction

`endif

// File: tb_back_end.sv
// seed fixed at 76469; outputs are sampled 1 ns after the falling edge for the coming rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_back_end import backend_cfg_pkg::*, backend_types_pkg::*; ();

    localparam int CLK_HALF    = 2;
    localparam int SEED        = 76469;
    localparam int HS_LIMIT    = 64;
    localparam int DRAIN_LIMIT = 400;
    localparam int RAND_N      = 400;

    `include "tb_ref_model.svh"

    logic            clk;
    logic            arst_n;
    logic            flush;
    logic            fetch_valid;
    logic            fetch_ready;
    logic [XLEN-1:0] fetch_pc;
    instr_word_u     fetch_instr;
    logic            comm_valid;
    comm_t           comm;

    int              err_value   = 0;
    int              err_proto   = 0;
    int              err_timeout = 0;
    int              accept_cnt  = 0;
    int              commit_cnt  = 0;
    bit              aborted     = 1'b0;
    logic [XLEN-1:0] pc_next     = '0;

    back_end dut0 (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .flush_i       (flush),
        .fetch_valid_i (fetch_valid),
        .fetch_ready_o (fetch_ready),
        .fetch_pc_i    (fetch_pc),
        .fetch_instr_i (fetch_instr),
        .comm_valid_o  (comm_valid),
        .comm_o        (comm)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_comm(input comm_t got, input comm_t want);
        if (got !== want) begin
            err_value++;
            $display("Error: comm_o at %0t got pc %h rd %h value %h, exp pc %h rd %h value %h",
                     $time, got.pc, got.rd, got.value, want.pc, want.rd, want.value);
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic want);
        if (got !== want) begin
            err_value++;
            $display("Error: %s at %0t got %h exp %h", name, $time, got, want);
        end
    endtask

    // commit compare, then flush drop, then the new handshake
    initial begin
        issued_t ins;
        comm_t   want;
        forever begin
            @(negedge clk);
            #1;
            if (arst_n) begin
                // ROB count equals the queue size before this edge
                if (flush || issued_q.size() >= ROB_DEPTH) begin
                    check_ready("fetch_ready_o", fetch_ready, 1'b0);
                end
                if (comm_valid) begin
                    if (issued_q.size() == 0) begin
                        err_proto++;
                        $display("commit of pc %h at %0t with no instruction in flight",
                                 comm.pc, $time);
                    end else begin
                        ins  = issued_q.pop_front();
                        want = ref_result(ins);
                        check_comm(comm, want);
                        model_commit(want);
                        commit_cnt++;
                    end
                end
                if (flush) begin
                    issued_q.delete();
                end
                if (fetch_valid && fetch_ready) begin
                    ins.pc   = fetch_pc;
                    ins.word = fetch_instr;
                    issued_q.push_back(ins);
                    accept_cnt++;
                end
            end
        end
    end

    function automatic logic [ILEN-1:0] op_rr(input logic [2:0] f3, input logic sub,
                                              input logic [REG_IDX_LEN-1:0] rd,
                                              input logic [REG_IDX_LEN-1:0] rs1,
                                              input logic [REG_IDX_LEN-1:0] rs2);
        return {sub ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [ILEN-1:0] op_ri(input logic [2:0] f3, input logic [11:0] imm,
                                              input logic [REG_IDX_LEN-1:0] rd,
                                              input logic [REG_IDX_LEN-1:0] rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // small register pool so that chains form often
    function automatic logic [ILEN-1:0] rand_instr();
        int                     pick;
        logic [2:0]             f3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [REG_IDX_LEN-1:0] rs1;
        logic [REG_IDX_LEN-1:0] rs2;
        pick = $urandom_range(99);
        case ($urandom_range(5))
            0:       f3 = 3'b000;
            1:       f3 = 3'b111;
            2:       f3 = 3'b110;
            3:       f3 = 3'b100;
            4:       f3 = 3'b010;
            default: f3 = 3'($urandom);
        endcase
        rd  = REG_IDX_LEN'($urandom_range(7));
        rs1 = REG_IDX_LEN'($urandom_range(7));
        rs2 = REG_IDX_LEN'($urandom_range(7));
        // a few raw words that mostly carry unsupported opcodes
        if (pick < 8) begin
            return ILEN'($urandom);
        end else if (pick < 54) begin
            return op_rr(f3, 1'($urandom), rd, rs1, rs2);
        end
        return op_ri(f3, 12'($urandom), rd, rs1);
    endfunction

    // hold valid and data until the monitor sees the handshake
    task automatic send_instr(input logic [ILEN-1:0] word);
        int start;
        int waited;
        if (aborted) begin
            return;
        end
        start       = accept_cnt;
        waited      = 0;
        fetch_valid = 1'b1;
        fetch_pc    = pc_next;
        fetch_instr = instr_word_u'(word);
        do begin
            @(negedge clk);
            waited++;
        end while (accept_cnt == start && waited < HS_LIMIT);
        fetch_valid = 1'b0;
        if (accept_cnt == start) begin
            err_timeout++;
            aborted = 1'b1;
            $display("timeout: fetch handshake not seen within %0d cycles", HS_LIMIT);
        end else begin
            pc_next += 4;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (issued_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (issued_q.size() != 0) begin
            err_timeout++;
            $display("timeout: %0d instructions never committed", issued_q.size());
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n      = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_instr = '0;
        model_reset();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        #1;
        check_ready("fetch_ready_o", fetch_ready, 1'b1);
        check_ready("comm_valid_o", comm_valid, 1'b0);
        @(negedge clk);

        // back-to-back chain through x1, then readers of it and an x0 write
        for (int k = 0; k < 8; k++) begin
            send_instr(op_ri(3'b000, 12'(k + 1), 5'd1, 5'd1));
        end
        send_instr(op_rr(3'b000, 1'b1, 5'd2, 5'd1, 5'd1));
        send_instr(op_ri(3'b000, 12'hfff, 5'd3, 5'd1));
        send_instr(op_rr(3'b010, 1'b0, 5'd4, 5'd3, 5'd1));
        send_instr(op_ri(3'b000, 12'h123, 5'd0, 5'd1));
        send_instr(op_rr(3'b110, 1'b0, 5'd5, 5'd0, 5'd1));

        // independent burst wider than the slots and the ROB
        for (int k = 0; k < 12; k++) begin
            send_instr(op_ri(3'b000, 12'(k * 3 + 1), REG_IDX_LEN'(8 + k % 8), 5'd0));
        end

        // random mix with gaps and occasional flushes
        for (int n = 0; n < RAND_N && !aborted; n++) begin
            send_instr(rand_instr());
            if ($urandom_range(3) == 0) begin
                idle_cycles($urandom_range(3, 1));
            end
            if ($urandom_range(39) == 0) begin
                pulse_flush();
            end
        end

        if (!aborted) begin
            wait_drain();
        end
        // late or duplicated commits would show here
        idle_cycles(8);

        $display("errors: value %0d, protocol %0d, timeout %0d; accepted %0d, committed %0d",
                 err_value, err_proto, err_timeout, accept_cnt, commit_cnt);
        if (err_value + err_proto + err_timeout == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
backend_cfg_pkg.sv
backend_types_pkg.sv
reg_state.sv
issue_stage.sv
exec_slot.sv
cdb_arbiter.sv
rob.sv
back_end.sv
tb_back_end.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_back_end
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
